// File: src/bus_params.svh
`ifndef BUS_PARAMS_SVH
`define BUS_PARAMS_SVH

// Bus masters, one request line each
`define NUM_SENDERS 11

// Destination receivers, one free line each
`define NUM_RECEIVERS 9

// FIFO entries, a power of two
`define QUEUE_DEPTH 4

// Width of a sender index or destination code
`define CODE_W 4

`endif

// File: src/busPkg.sv
`default_nettype none
`include "bus_params.svh"

package busPkg;

    typedef enum logic [`CODE_W-1:0] {
        B3  = 4'd0,     // Lowest priority
        B2  = 4'd1,
        B1  = 4'd2,
        B0  = 4'd3,
        DOW = 4'd4,
        DOR = 4'd5,
        DEW = 4'd6,
        DER = 4'd7,
        IO  = 4'd8,
        IE  = 4'd9,
        DMA = 4'd10     // Highest priority
    } senderT;

    typedef enum logic [`CODE_W-1:0] {
        RIE  = 4'd0,
        RIO  = 4'd1,
        RDE  = 4'd2,
        RDO  = 4'd3,
        RB0  = 4'd4,
        RB1  = 4'd5,
        RB2  = 4'd6,
        RB3  = 4'd7,
        RDMA = 4'd8
    } receiverT;

    typedef struct packed {
        senderT   sender;
        receiverT dest;
    } busReqT;

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } bauStateT;

endpackage

`default_nettype wire

// File: src/reqQueueIf.sv
`timescale 1ns/1ps
`default_nettype none

interface reqQueueIf
    import busPkg::*;
();

    logic     ready;    // Head valid and its receiver free
    senderT   sender;
    receiverT dest;
    logic     pull;     // Pop the head at this edge

    modport queue (
        output ready,
        output sender,
        output dest,
        input  pull
    );

    modport arbiter (
        input  ready,
        input  sender,
        input  dest,
        output pull
    );

endinterface

`default_nettype wire

// File: src/reqQueue.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module reqQueue
    import busPkg::*;
(
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [`NUM_SENDERS-1:0]             req,
    input  logic [`NUM_RECEIVERS-1:0]           free,
    input  logic [`NUM_SENDERS*`CODE_W-1:0]     dest,
    output logic [`NUM_SENDERS-1:0]             ack,
    reqQueueIf.queue                            qIf
);

    localparam int PTR_W = $clog2(`QUEUE_DEPTH);

    logic [`NUM_SENDERS-1:0] pending;
    logic                    anyReq;
    senderT                  selSender;
    receiverT                selDest;
    busReqT                  head;

    busReqT                  mem [`QUEUE_DEPTH];
    logic [PTR_W-1:0]        wrPtr;
    logic [PTR_W-1:0]        rdPtr;
    logic [PTR_W:0]          count;

    logic                    full;
    logic                    empty;
    logic                    push;
    logic                    pop;

    // A master still shows req in its ack cycle
    assign pending = req & ~ack;

    // Highest index wins, so the last hit in the loop is kept
    always_comb begin
        anyReq    = 1'b0;
        selSender = B3;
        for (int i = 0; i < `NUM_SENDERS; i++) begin
            if (pending[i]) begin
                anyReq    = 1'b1;
                selSender = senderT'(i);
            end
        end
    end

    assign selDest = receiverT'(dest[selSender*`CODE_W +: `CODE_W]);

    assign full  = (count == (PTR_W+1)'(`QUEUE_DEPTH));
    assign empty = (count == '0);
    assign push  = anyReq && !full;
    assign pop   = qIf.ready && qIf.pull;

    // Entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= '{sender: selSender, dest: selDest};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (push) begin
                wrPtr <= wrPtr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rdPtr <= rdPtr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
        end else begin
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    // One-cycle ack for the accepted sender
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= '0;
        end else begin
            ack <= '0;
            if (push) begin
                ack[selSender] <= 1'b1;
            end
        end
    end

    assign head = mem[rdPtr];

    assign qIf.sender = head.sender;
    assign qIf.dest   = head.dest;

    // Busy receiver at the head blocks everything behind it
    assign qIf.ready  = !empty && free[head.dest];

endmodule

`default_nettype wire

// File: src/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module busArbiter
    import busPkg::*;
(
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [`NUM_SENDERS-1:0]     rel,
    output logic [`NUM_SENDERS-1:0]     grant,
    output logic [`NUM_RECEIVERS-1:0]   recv,
    reqQueueIf.arbiter                  qIf
);

    bauStateT state;
    bauStateT nextState;
    senderT   owner;
    receiverT ownerDest;
    logic     ownerRel;
    logic     take;

    // Only the current owner can end the transfer
    assign ownerRel = rel[owner];

    assign take     = (state == IDLE) && qIf.ready;
    assign qIf.pull = take;

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (take) begin
                    nextState = BUSY;
                end
            end
            BUSY: begin
                if (ownerRel) begin
                    nextState = IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Latch the head as it is popped
    always_ff @(posedge clk) begin
        if (take) begin
            owner     <= qIf.sender;
            ownerDest <= qIf.dest;
        end
    end

    // One-hot grant to the owner
    always_comb begin
        grant = '0;
        for (int i = 0; i < `NUM_SENDERS; i++) begin
            if (state == BUSY && owner == senderT'(i)) begin
                grant[i] = 1'b1;
            end
        end
    end

    // One-hot recv to the owner's destination
    always_comb begin
        recv = '0;
        for (int j = 0; j < `NUM_RECEIVERS; j++) begin
            if (state == BUSY && ownerDest == receiverT'(j)) begin
                recv[j] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/busTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module busTop (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic [`NUM_SENDERS-1:0]             req,
    input  logic [`NUM_SENDERS*`CODE_W-1:0]     dest,   // 4 bits per sender
    input  logic [`NUM_RECEIVERS-1:0]           free,
    input  logic [`NUM_SENDERS-1:0]             rel,
    output logic [`NUM_SENDERS-1:0]             ack,
    output logic [`NUM_SENDERS-1:0]             grant,
    output logic [`NUM_RECEIVERS-1:0]           recv
);

    // Head offer and pull between queue and arbiter
    reqQueueIf qIf ();

    reqQueue i_reqQueue (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .free  (free),
        .dest  (dest),
        .ack   (ack),
        .qIf   (qIf.queue)
    );

    busArbiter i_busArbiter (
        .clk   (clk),
        .arstN (arstN),
        .rel   (rel),
        .grant (grant),
        .recv  (recv),
        .qIf   (qIf.arbiter)
    );

endmodule

`default_nettype wire

// File: testbench/busChk.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module busChk (
    input logic                              clk,
    input logic                              arstN,
    input logic [`NUM_SENDERS-1:0]           req,
    input logic [`NUM_SENDERS*`CODE_W-1:0]   dest,
    input logic [`NUM_SENDERS-1:0]           ack,
    input logic [`NUM_SENDERS-1:0]           grant,
    input logic [`NUM_RECEIVERS-1:0]         recv,
    input logic [`NUM_SENDERS-1:0]           rel
);

    ackOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(ack))
        else $error("ack has more than one bit set");

    grantOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(grant))
        else $error("grant has more than one bit set");

    recvOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot0(recv))
        else $error("recv has more than one bit set");

    grantRecvPaired: assert property (@(posedge clk) disable iff (!arstN)
        (grant != '0) == (recv != '0))
        else $error("grant and recv disagree on bus ownership");

    // Owner keeps the bus until it releases
    grantStable: assert property (@(posedge clk) disable iff (!arstN)
        (grant != '0 && (grant & rel) == '0) |=> $stable(grant))
        else $error("grant changed without a release from the owner");

    for (genvar i = 0; i < `NUM_SENDERS; i++) begin : destCheck
        destInRange: assert property (@(posedge clk) disable iff (!arstN)
            req[i] |-> dest[i*`CODE_W +: `CODE_W] < 4'(`NUM_RECEIVERS))
            else $error("master %0d requests an unknown destination", i);
    end

endmodule

bind busTop busChk i_busChk (
    .clk   (clk),
    .arstN (arstN),
    .req   (req),
    .dest  (dest),
    .ack   (ack),
    .grant (grant),
    .recv  (recv),
    .rel   (rel)
);

`default_nettype wire

// File: testbench/busTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_params.svh"

module busTb
    import busPkg::*;
();

    // About 400 cycles of directed tests plus 40 random transfers of up to 20 cycles
    localparam int CYCLE_LIMIT = 3000;

    logic                                clk = 1'b0;
    logic                                arstN;
    logic [`NUM_SENDERS-1:0]             req;
    logic [`NUM_SENDERS*`CODE_W-1:0]     dest;
    logic [`NUM_RECEIVERS-1:0]           free;
    logic [`NUM_SENDERS-1:0]             rel;
    logic [`NUM_SENDERS-1:0]             ack;
    logic [`NUM_SENDERS-1:0]             grant;
    logic [`NUM_RECEIVERS-1:0]           recv;

    busReqT                  refQ [$];  // Accepted requests in ack order
    senderT                  ackLog [$];
    int                      ackCycles [$];
    logic [31:0]             lfsr = 32'h3009_1bb1;
    int                      cycleCount = 0;
    int                      grantCount = 0;
    int                      holdLeft = 0;
    bit                      autoRel = 1'b1;
    bit                      randHold = 1'b0;
    logic [`NUM_SENDERS-1:0] lastGrant = '0;
    senderT                  owner = B3;

    busTop i_busTop (
        .clk   (clk),
        .arstN (arstN),
        .req   (req),
        .dest  (dest),
        .free  (free),
        .rel   (rel),
        .ack   (ack),
        .grant (grant),
        .recv  (recv)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TB FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic mismatch(input string msg);
        $display("FAILED at %0d ns: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "wrong value");
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped");
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic int nextBits(input int n);
        int val;
        val = 0;
        for (int k = 0; k < n; k++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic logic [`NUM_SENDERS-1:0] senderBit(input senderT s);
        logic [`NUM_SENDERS-1:0] v;
        v    = '0;
        v[s] = 1'b1;
        return v;
    endfunction

    function automatic logic [`NUM_RECEIVERS-1:0] receiverBit(input receiverT r);
        logic [`NUM_RECEIVERS-1:0] v;
        v    = '0;
        v[r] = 1'b1;
        return v;
    endfunction

    // Advance to the next falling edge and play the masters there
    task automatic tick();
        busReqT entry;
        busReqT head;
        @(negedge clk);
        rel = '0;
        for (int i = 0; i < `NUM_SENDERS; i++) begin
            if (ack[i]) begin
                assert (req[i]) else abortRun($sformatf("ack for master %0d without req", i));
                entry.sender = senderT'(i);
                entry.dest   = receiverT'(dest[i*`CODE_W +: `CODE_W]);
                refQ.push_back(entry);
                ackLog.push_back(senderT'(i));
                ackCycles.push_back(cycleCount);
                req[i] = 1'b0;  // Master drops req once acked
            end
        end
        if (grant != '0 && lastGrant == '0) begin
            assert (refQ.size() > 0) else abortRun("grant appeared with no accepted request");
            head = refQ.pop_front();
            assert (grant == senderBit(head.sender) && recv == receiverBit(head.dest))
                else mismatch($sformatf("grant %b recv %b, expected sender %s dest %s",
                    grant, recv, head.sender.name(), head.dest.name()));
            owner    = head.sender;
            holdLeft = randHold ? nextBits(3) : 2;
            grantCount++;
        end
        if (grant != '0 && autoRel) begin
            if (holdLeft == 0) begin
                rel[owner] = 1'b1;
            end else begin
                holdLeft--;
            end
        end
        lastGrant = grant;
    endtask

    task automatic raise(input senderT s, input receiverT d);
        dest[s*`CODE_W +: `CODE_W] = d;
        req[s] = 1'b1;
    endtask

    task automatic waitAck(input senderT s);
        tick();
        while (!ack[s]) begin
            tick();
        end
    endtask

    task automatic drain();
        tick();
        while (refQ.size() != 0 || req != '0 || grant != '0) begin
            tick();
        end
    endtask

    task automatic checkReset();
        for (int k = 0; k < 5; k++) begin
            tick();
            assert (ack == '0 && grant == '0 && recv == '0)
                else mismatch($sformatf("not idle: ack %b grant %b recv %b", ack, grant, recv));
        end
    endtask

    task automatic singleTransfer();
        int base;
        base    = grantCount;
        autoRel = 1'b0;
        raise(IE, RIO);
        waitAck(IE);
        tick();
        assert (ack == '0) else mismatch("ack lasted longer than one cycle");
        while (grantCount == base) begin
            tick();
        end
        repeat (3) begin
            rel[DMA] = 1'b1;    // Release from a master that does not own the bus
            tick();
            assert (grant == senderBit(IE) && recv == receiverBit(RIO))
                else mismatch($sformatf("held grant %b recv %b changed", grant, recv));
        end
        rel[IE] = 1'b1;
        tick();
        assert (grant == '0 && recv == '0) else mismatch("grant or recv still high after rel");
        autoRel = 1'b1;
        drain();
    endtask

    task automatic priorityOrder();
        int base;
        base = grantCount;
        ackLog.delete();
        ackCycles.delete();
        raise(B1, RB1);
        raise(DOW, RDE);
        raise(IO, RIE);
        raise(DMA, RDMA);
        while (grantCount < base + 4) begin
            tick();
        end
        assert (ackLog.size() == 4 && ackLog[0] == DMA && ackLog[1] == IO
                && ackLog[2] == DOW && ackLog[3] == B1)
            else mismatch("acks not in priority order");
        for (int k = 0; k < 3; k++) begin
            assert (ackCycles[k+1] == ackCycles[k] + 1)
                else mismatch($sformatf("acks %0d and %0d not in consecutive cycles", k, k + 1));
        end
        drain();
    endtask

    task automatic receiverBackPressure();
        int base;
        base      = grantCount;
        free[RB2] = 1'b0;
        raise(DER, RB2);
        waitAck(DER);
        raise(DMA, RIE);
        waitAck(DMA);
        repeat (8) begin
            tick();
            assert (grant == '0) else mismatch("grant passed a busy head receiver");
        end
        free[RB2] = 1'b1;
        while (grantCount < base + 2) begin
            tick();
        end
        drain();
    endtask

    task automatic fullQueue();
        int base;
        base    = grantCount;
        autoRel = 1'b0;
        raise(DMA, RDMA);
        while (grantCount == base) begin
            tick();
        end
        free[RB0] = 1'b0;
        ackLog.delete();
        raise(B3, RB0);
        raise(B2, RB0);
        raise(B1, RB0);
        raise(B0, RB0);
        raise(DOW, RB0);
        while (ackLog.size() < 4) begin
            tick();
        end
        repeat (6) begin
            tick();
            assert (ack == '0 && req[B3])
                else mismatch("fifth request accepted by a full queue");
        end
        free[RB0] = 1'b1;
        rel[DMA]  = 1'b1;
        autoRel   = 1'b1;
        waitAck(B3);
        assert (grantCount == base + 2) else mismatch("fifth ack did not follow the pull");
        drain();
    endtask

    task automatic randomTraffic();
        senderT   s;
        receiverT d;
        int       base;
        base     = grantCount;
        randHold = 1'b1;
        for (int k = 0; k < 40; k++) begin
            s = senderT'(nextBits(4) % `NUM_SENDERS);
            d = receiverT'(nextBits(4) % `NUM_RECEIVERS);
            while (req[s]) begin
                tick();
            end
            raise(s, d);
            repeat (nextBits(2)) begin
                tick();
            end
        end
        drain();
        assert (grantCount == base + 40)
            else mismatch($sformatf("%0d random grants, expected 40", grantCount - base));
        randHold = 1'b0;
    endtask

    initial begin
        arstN = 1'b0;
        req   = '0;
        dest  = '0;
        free  = '1;
        rel   = '0;
        repeat (4) @(negedge clk);
        arstN = 1'b1;
        checkReset();
        singleTransfer();
        priorityOrder();
        receiverBackPressure();
        fullQueue();
        randomTraffic();
        assert (refQ.size() == 0 && grant == '0) else abortRun("transfers left over at the end");
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+src
src/busPkg.sv
src/reqQueueIf.sv
src/reqQueue.sv
src/busArbiter.sv
src/busTop.sv
testbench/busChk.sv
testbench/busTb.sv

// File: build.sh
#!/usr/bin/env bash
# Compile the bus testbench with Verilator and run the model
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module busTb -o busSim
./obj_dir/busSim
